// File: source/soc_pkg.sv
package soc_pkg;

    // APB request from the processor side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response back to the processor side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // One decoded keyboard event
    typedef struct packed {
        logic       valid;
        logic       released;
        logic [7:0] scan;
        logic [7:0] ascii;
    } key_evt_t;

    // Memory map
    localparam logic [15:0] ram_base       = 16'h1000;
    // Last key, read only
    localparam logic [15:0] key_addr       = 16'h2000;
    // Console byte, write only
    localparam logic [15:0] uart_data_addr = 16'h2004;
    // Console status, bit 0 busy
    localparam logic [15:0] uart_stat_addr = 16'h2008;
    // Vector read, any write acks
    localparam logic [15:0] irq_addr       = 16'h200C;

endpackage

// File: source/soc_bus_ctrl.sv
module soc_bus_ctrl
    import soc_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  apb_req_t    bus_req,
    output apb_rsp_t    bus_rsp,
    output logic        ram_sel,
    input  logic        ram_ready,
    input  logic [31:0] ram_rdata,
    output logic        key_sel,
    input  logic        key_ready,
    input  logic [31:0] key_rdata,
    output logic        uart_data_sel,
    input  logic        uart_data_ready,
    input  logic [31:0] uart_data_rdata,
    output logic        uart_stat_sel,
    input  logic        uart_stat_ready,
    input  logic [31:0] uart_stat_rdata,
    output logic        irq_sel,
    input  logic        irq_ready,
    input  logic [31:0] irq_rdata
);

    typedef struct packed {
        logic ram;
        logic key;
        logic uart_data;
        logic uart_stat;
        logic irq;
    } sel_t;

    localparam int unsigned RAM_BYTES = RAM_WORDS * 4;

    sel_t        dec;
    sel_t        sel_q;
    logic        err_q;
    logic [15:0] ram_off;
    logic        setup;
    logic        done;

    assign ram_off = bus_req.paddr - ram_base;

    // Address decode, read-only targets reject writes
    always_comb begin
        dec           = '0;
        dec.ram       = (bus_req.paddr >= ram_base) && (32'(ram_off) < RAM_BYTES);
        dec.key       = (bus_req.paddr == key_addr) && !bus_req.pwrite;
        dec.uart_data = (bus_req.paddr == uart_data_addr);
        dec.uart_stat = (bus_req.paddr == uart_stat_addr) && !bus_req.pwrite;
        dec.irq       = (bus_req.paddr == irq_addr);
    end

    assign setup = bus_req.psel && !bus_req.penable;
    assign done  = bus_req.psel && bus_req.penable && bus_rsp.pready;

    // Select and error flag captured in the setup cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sel_q <= '0;
            err_q <= 1'b0;
        end else if (setup) begin
            sel_q <= dec;
            // Nothing hit, so fail in the first access cycle
            err_q <= (dec == '0);
        end else if (done || !bus_req.psel) begin
            sel_q <= '0;
            err_q <= 1'b0;
        end
    end

    assign ram_sel       = sel_q.ram;
    assign key_sel       = sel_q.key;
    assign uart_data_sel = sel_q.uart_data;
    assign uart_stat_sel = sel_q.uart_stat;
    assign irq_sel       = sel_q.irq;

    // Response mux, only the selected target reaches the bus
    always_comb begin
        bus_rsp = '0;
        if (bus_req.psel && bus_req.penable) begin
            bus_rsp.pslverr = err_q;
            bus_rsp.pready  = err_q
                            | (sel_q.ram       & ram_ready)
                            | (sel_q.key       & key_ready)
                            | (sel_q.uart_data & uart_data_ready)
                            | (sel_q.uart_stat & uart_stat_ready)
                            | (sel_q.irq       & irq_ready);
            bus_rsp.prdata  = ({32{sel_q.ram}}       & ram_rdata)
                            | ({32{sel_q.key}}       & key_rdata)
                            | ({32{sel_q.uart_data}} & uart_data_rdata)
                            | ({32{sel_q.uart_stat}} & uart_stat_rdata)
                            | ({32{sel_q.irq}}       & irq_rdata);
        end
    end

endmodule

// File: source/onchip_ram.sv
module onchip_ram
    import soc_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic        CLOCK_50,
    input  logic        sel,
    input  apb_req_t    bus_req,
    output logic        ready,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [15:0]   byte_off;
    logic [AW-1:0] word_idx;
    logic          rd_ready_q;
    logic          rd_access;

    // Word index relative to the start of RAM
    assign byte_off = bus_req.paddr - ram_base;
    assign word_idx = byte_off[AW+1:2];

    assign rd_access = sel && bus_req.penable && !bus_req.pwrite;

    // Full word write in the access cycle
    always_ff @(posedge CLOCK_50) begin
        if (sel && bus_req.penable && bus_req.pwrite) begin
            mem[word_idx] <= bus_req.pwdata;
        end
    end

    // Read data lands one cycle into the access phase
    always_ff @(posedge CLOCK_50) begin
        if (rd_access) begin
            rdata <= mem[word_idx];
        end
    end

    // One wait state on reads
    // Drops again once the read has completed
    always_ff @(posedge CLOCK_50) begin
        rd_ready_q <= rd_access && !rd_ready_q;
    end

    // Writes finish straight away
    assign ready = sel && (bus_req.pwrite || rd_ready_q);

endmodule

// File: source/ps2_receiver.sv
module ps2_receiver
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     ps2_clk,
    input  logic     ps2_dat,
    output key_evt_t key_evt
);

    logic [2:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_fall;
    logic [9:0]  frame_q;
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic        frame_ok;
    logic        brk_q;

    // Set 2 scan code to lower case ASCII
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        case (code)
            8'h1C: scan_to_ascii = 8'h61;
            8'h32: scan_to_ascii = 8'h62;
            8'h21: scan_to_ascii = 8'h63;
            8'h23: scan_to_ascii = 8'h64;
            8'h24: scan_to_ascii = 8'h65;
            8'h2B: scan_to_ascii = 8'h66;
            8'h34: scan_to_ascii = 8'h67;
            8'h33: scan_to_ascii = 8'h68;
            8'h43: scan_to_ascii = 8'h69;
            8'h3B: scan_to_ascii = 8'h6A;
            8'h42: scan_to_ascii = 8'h6B;
            8'h4B: scan_to_ascii = 8'h6C;
            8'h3A: scan_to_ascii = 8'h6D;
            8'h31: scan_to_ascii = 8'h6E;
            8'h44: scan_to_ascii = 8'h6F;
            8'h4D: scan_to_ascii = 8'h70;
            8'h15: scan_to_ascii = 8'h71;
            8'h2D: scan_to_ascii = 8'h72;
            8'h1B: scan_to_ascii = 8'h73;
            8'h2C: scan_to_ascii = 8'h74;
            8'h3C: scan_to_ascii = 8'h75;
            8'h2A: scan_to_ascii = 8'h76;
            8'h1D: scan_to_ascii = 8'h77;
            8'h22: scan_to_ascii = 8'h78;
            8'h35: scan_to_ascii = 8'h79;
            8'h1A: scan_to_ascii = 8'h7A;
            8'h45: scan_to_ascii = 8'h30;
            8'h16: scan_to_ascii = 8'h31;
            8'h1E: scan_to_ascii = 8'h32;
            8'h26: scan_to_ascii = 8'h33;
            8'h25: scan_to_ascii = 8'h34;
            8'h2E: scan_to_ascii = 8'h35;
            8'h36: scan_to_ascii = 8'h36;
            8'h3D: scan_to_ascii = 8'h37;
            8'h3E: scan_to_ascii = 8'h38;
            8'h46: scan_to_ascii = 8'h39;
            default: scan_to_ascii = 8'h00;
        endcase
    endfunction

    // Both lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    assign clk_fall = clk_sync[2] && !clk_sync[1];

    // Bits arrive LSB first, shift in from the top
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame_q <= {dat_sync[1], frame_q[9:1]};
        end
    end

    // Stop bit joins the first ten
    assign frame    = {dat_sync[1], frame_q};
    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt <= 4'd0;
            brk_q   <= 1'b0;
            key_evt <= '0;
        end else begin
            key_evt.valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= 4'd0;
                    if (frame_ok && frame[8:1] == 8'hF0) begin
                        // Break prefix, next code is a release
                        brk_q <= 1'b1;
                    end else if (frame_ok) begin
                        brk_q            <= 1'b0;
                        key_evt.valid    <= 1'b1;
                        key_evt.released <= brk_q;
                        key_evt.scan     <= frame[8:1];
                        key_evt.ascii    <= scan_to_ascii(frame[8:1]);
                    end
                end else if (bit_cnt != 4'd0 || !dat_sync[1]) begin
                    // Wait for a low start bit before counting
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// File: source/key_irq_ctrl.sv
module key_irq_ctrl
    import soc_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  key_evt_t    key_evt,
    input  logic        key_sel,
    input  logic        irq_sel,
    input  apb_req_t    bus_req,
    output logic [31:0] key_rdata,
    output logic [31:0] irq_rdata,
    output logic [3:0]  irq_vector
);

    logic [7:0] key_q;
    logic       make_evt;
    logic       irq_ack;

    // Press only, break codes never touch the key
    assign make_evt = key_evt.valid && !key_evt.released;

    // Any write to the vector address acknowledges
    assign irq_ack = irq_sel && bus_req.penable && bus_req.pwrite;

    // Last pressed key
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q <= 8'd0;
        end else if (make_evt) begin
            key_q <= key_evt.ascii;
        end
    end

    // Vector 1 for keyboard
    // Held until acked, repeat presses add nothing
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else if (irq_ack) begin
            irq_vector <= 4'd0;
        end else if (make_evt && key_evt.ascii != 8'd0 && irq_vector == 4'd0) begin
            irq_vector <= 4'd1;
        end
    end

    // Read data only while addressed
    assign key_rdata = key_sel ? {24'd0, key_q} : 32'd0;
    assign irq_rdata = irq_sel ? {28'd0, irq_vector} : 32'd0;

endmodule

// File: source/uart_tx_port.sv
module uart_tx_port
    import soc_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        data_sel,
    input  logic        stat_sel,
    input  apb_req_t    bus_req,
    output logic        data_ready,
    output logic [31:0] stat_rdata,
    output logic        txd
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic          busy;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [8:0]    shreg;
    logic          start;
    logic          bit_end;

    // Write completes here, so the frame begins next cycle
    assign start   = data_sel && bus_req.penable && bus_req.pwrite && !busy;
    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    // Data bits then stop bit, shifted out LSB first
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            shreg <= {1'b1, bus_req.pwdata[7:0]};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= 4'd0;
        end else if (start) begin
            busy    <= 1'b1;
            // Start bit
            txd     <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= 4'd0;
        end else if (busy) begin
            clk_cnt <= bit_end ? '0 : clk_cnt + CW'(1);
            if (bit_end) begin
                if (bit_idx == 4'd9) begin
                    // End of stop bit
                    busy <= 1'b0;
                    txd  <= 1'b1;
                end else begin
                    txd     <= shreg[0];
                    bit_idx <= bit_idx + 4'd1;
                end
            end
        end
    end

    // Back-pressure while a frame is on the line
    assign data_ready = data_sel && !busy;
    assign stat_rdata = stat_sel ? {31'd0, busy} : 32'd0;

endmodule

// File: source/soc_top.sv
module soc_top
    import soc_pkg::*;
#(
    parameter int RAM_WORDS    = 1024,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  apb_req_t   bus_req,
    output apb_rsp_t   bus_rsp,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic       uart_txd,
    output logic [3:0] irq_vector
);

    logic        ram_sel;
    logic        ram_ready;
    logic [31:0] ram_rdata;
    logic        key_sel;
    logic [31:0] key_rdata;
    logic        irq_sel;
    logic [31:0] irq_rdata;
    logic        uart_data_sel;
    logic        uart_data_ready;
    logic        uart_stat_sel;
    logic [31:0] uart_stat_rdata;
    key_evt_t    key_evt;

    // Register targets answer at once, data register reads as zero
    soc_bus_ctrl #(.RAM_WORDS(RAM_WORDS)) u_bus_ctrl (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_req         (bus_req),
        .bus_rsp         (bus_rsp),
        .ram_sel         (ram_sel),
        .ram_ready       (ram_ready),
        .ram_rdata       (ram_rdata),
        .key_sel         (key_sel),
        .key_ready       (1'b1),
        .key_rdata       (key_rdata),
        .uart_data_sel   (uart_data_sel),
        .uart_data_ready (uart_data_ready),
        .uart_data_rdata (32'd0),
        .uart_stat_sel   (uart_stat_sel),
        .uart_stat_ready (1'b1),
        .uart_stat_rdata (uart_stat_rdata),
        .irq_sel         (irq_sel),
        .irq_ready       (1'b1),
        .irq_rdata       (irq_rdata)
    );

    onchip_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .CLOCK_50 (CLOCK_50),
        .sel      (ram_sel),
        .bus_req  (bus_req),
        .ready    (ram_ready),
        .rdata    (ram_rdata)
    );

    // Keyboard path into the interrupt logic
    ps2_receiver u_ps2 (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .key_evt  (key_evt)
    );

    key_irq_ctrl u_key_irq (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_evt    (key_evt),
        .key_sel    (key_sel),
        .irq_sel    (irq_sel),
        .bus_req    (bus_req),
        .key_rdata  (key_rdata),
        .irq_rdata  (irq_rdata),
        .irq_vector (irq_vector)
    );

    // Serial console
    uart_tx_port #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .data_sel   (uart_data_sel),
        .stat_sel   (uart_stat_sel),
        .bus_req    (bus_req),
        .data_ready (uart_data_ready),
        .stat_rdata (uart_stat_rdata),
        .txd        (uart_txd)
    );

endmodule

// File: sim/soc_tb.sv
module soc_tb
    import soc_pkg::*;
();

    localparam int RAM_WORDS    = 1024;
    localparam int CLKS_PER_BIT = 8;
    localparam int RESET_CYCLES = 5;
    // PS/2 clock half period in system cycles
    localparam int PS2_HALF     = 10;
    localparam int PS2_GAP      = 20;
    localparam int PS2_FRAMES   = 4;
    localparam int SER_FRAMES   = 2;
    localparam int RAM_TESTS    = 8;
    // RAM pairs, fixed register accesses and the status poll bound
    localparam int APB_ACCESSES = 2 * RAM_TESTS + 18 + 10 * CLKS_PER_BIT;
    // Keyboard frames, serial frames and bus accesses plus margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES
                                  + PS2_FRAMES * (22 * PS2_HALF + PS2_GAP)
                                  + SER_FRAMES * 10 * CLKS_PER_BIT
                                  + APB_ACCESSES * 4
                                  + 500;

    logic       CLOCK_50 = 1'b0;
    logic       KEY0;
    apb_req_t   bus_req;
    apb_rsp_t   bus_rsp;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       uart_txd;
    logic [3:0] irq_vector;

    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    // Bytes decoded off the serial line
    logic [7:0] rx_bytes[$];

    soc_top #(
        .RAM_WORDS    (RAM_WORDS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_dut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .uart_txd   (uart_txd),
        .irq_vector (irq_vector)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    // Ready only inside an access cycle
    pready_in_access: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_rsp.pready |-> (bus_req.psel && bus_req.penable))
    else begin
        errors++;
        $display("APB rule broken: pready high outside an access cycle");
    end

    // Error flag only on the completing cycle
    slverr_on_done: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_rsp.pslverr |-> bus_rsp.pready)
    else begin
        errors++;
        $display("APB rule broken: pslverr high without pready");
    end

    // Levels as reset lets go
    reset_levels: assert property (@(posedge CLOCK_50)
        $rose(KEY0) |-> (!bus_rsp.pready && !bus_rsp.pslverr && uart_txd && irq_vector == 4'd0))
    else begin
        errors++;
        $display("Outputs not at their reset levels when reset was released");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One APB transfer entered and left just after a rising edge
    task automatic apb_access(input logic wr, input logic [15:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int waits);
        bus_req.psel    = 1'b1;
        bus_req.penable = 1'b0;
        bus_req.pwrite  = wr;
        bus_req.paddr   = addr;
        bus_req.pwdata  = wdata;
        @(posedge CLOCK_50);
        #1;
        bus_req.penable = 1'b1;
        waits = 0;
        // Sampled mid-cycle where the response is settled
        @(negedge CLOCK_50);
        while (!bus_rsp.pready) begin
            waits++;
            @(negedge CLOCK_50);
        end
        rdata = bus_rsp.prdata;
        err   = bus_rsp.pslverr;
        @(posedge CLOCK_50);
        #1;
        bus_req = '0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic err, output int waits);
        logic [31:0] rdata;
        apb_access(1'b1, addr, data, rdata, err, waits);
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata,
                            output logic err, output int waits);
        apb_access(1'b0, addr, 32'd0, rdata, err, waits);
    endtask

    // Start, 8 data bits LSB first, parity, stop
    task automatic ps2_send(input logic [7:0] code, input logic good_parity);
        logic [10:0] frame;
        logic        parity;
        // Odd parity flipped for a corrupt frame
        parity = good_parity ? ~^code : ^code;
        frame  = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = frame[i];
            repeat (PS2_HALF) @(posedge CLOCK_50);
            #1;
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(posedge CLOCK_50);
            #1;
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        repeat (PS2_GAP) @(posedge CLOCK_50);
        #1;
    endtask

    // 8N1 decoder sampling near bit centers
    initial begin : serial_monitor
        logic [7:0] rx_byte;
        forever begin
            @(negedge uart_txd);
            repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
            assert (uart_txd == 1'b0) else begin
                errors++;
                $display("Serial monitor: start bit did not stay low");
            end
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
                rx_byte[b] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
            assert (uart_txd == 1'b1) else begin
                errors++;
                $display("Serial monitor: stop bit missing after byte %h", rx_byte);
            end
            rx_bytes.push_back(rx_byte);
        end
    end

    // Watchdog
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Result: %0d checks, %0d errors", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin : main
        logic [31:0] rdata;
        logic        err;
        int          waits;
        int          polls;
        logic [15:0] ram_addr[RAM_TESTS];
        logic [31:0] ram_data[RAM_TESTS];

        void'($urandom(32'h17d2_4558));
        KEY0    = 1'b0;
        bus_req = '0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        @(posedge CLOCK_50);
        #1;

        // Reset state
        check_value("reset_txd", 32'd1, {31'd0, uart_txd});
        check_value("reset_irq", 32'd0, {28'd0, irq_vector});
        apb_read(key_addr, rdata, err, waits);
        check_value("reset_key", 32'd0, rdata);
        check_value("reset_key_err", 32'd0, {31'd0, err});
        check_value("reset_key_waits", 32'd0, waits);

        // One RAM word per 128-word slice so no two collide
        for (int i = 0; i < RAM_TESTS; i++) begin
            ram_addr[i] = ram_base + 16'((i * 128 + int'($urandom % 128)) * 4);
            ram_data[i] = $urandom;
            apb_write(ram_addr[i], ram_data[i], err, waits);
            check_value("ram_write_err", 32'd0, {31'd0, err});
            check_value("ram_write_waits", 32'd0, waits);
        end
        for (int i = 0; i < RAM_TESTS; i++) begin
            apb_read(ram_addr[i], rdata, err, waits);
            check_value("ram_read_data", ram_data[i], rdata);
            check_value("ram_read_err", 32'd0, {31'd0, err});
            check_value("ram_read_waits", 32'd1, waits);
        end

        // Error responses
        apb_write(16'h3000, 32'hDEAD_BEEF, err, waits);
        check_value("unmapped_write_err", 32'd1, {31'd0, err});
        check_value("unmapped_write_waits", 32'd0, waits);
        apb_read(16'h0040, rdata, err, waits);
        check_value("unmapped_read_err", 32'd1, {31'd0, err});
        apb_write(key_addr, 32'h0000_0055, err, waits);
        check_value("key_write_err", 32'd1, {31'd0, err});
        apb_write(uart_stat_addr, 32'h0000_0001, err, waits);
        check_value("stat_write_err", 32'd1, {31'd0, err});
        // Nothing else moved
        check_value("err_txd_idle", 32'd1, {31'd0, uart_txd});
        apb_read(key_addr, rdata, err, waits);
        check_value("err_key_kept", 32'd0, rdata);
        apb_read(irq_addr, rdata, err, waits);
        check_value("err_irq_kept", 32'd0, rdata);
        apb_read(uart_stat_addr, rdata, err, waits);
        check_value("err_stat_kept", 32'd0, rdata);
        apb_read(ram_addr[0], rdata, err, waits);
        check_value("err_ram_kept", ram_data[0], rdata);

        // Press of a
        ps2_send(8'h1C, 1'b1);
        polls = 0;
        while (irq_vector !== 4'd1 && polls < 4 * PS2_HALF) begin
            @(posedge CLOCK_50);
            #1;
            polls++;
        end
        check_value("key_irq_raise", 32'd1, {28'd0, irq_vector});
        apb_read(key_addr, rdata, err, waits);
        check_value("key_ascii_a", 32'h61, rdata);
        apb_read(irq_addr, rdata, err, waits);
        check_value("irq_read_vector", 32'd1, rdata);
        check_value("irq_read_waits", 32'd0, waits);
        // Ack clears the vector on the next cycle
        apb_write(irq_addr, 32'd0, err, waits);
        check_value("irq_ack_clear", 32'd0, {28'd0, irq_vector});

        // Release of a
        ps2_send(8'hF0, 1'b1);
        ps2_send(8'h1C, 1'b1);
        check_value("break_no_irq", 32'd0, {28'd0, irq_vector});
        apb_read(key_addr, rdata, err, waits);
        check_value("break_key_kept", 32'h61, rdata);

        // Corrupt b frame
        ps2_send(8'h32, 1'b0);
        check_value("parity_no_irq", 32'd0, {28'd0, irq_vector});
        apb_read(key_addr, rdata, err, waits);
        check_value("parity_key_kept", 32'h61, rdata);

        // Second console write stalls for the whole first frame
        apb_write(uart_data_addr, 32'h48, err, waits);
        check_value("uart_first_waits", 32'd0, waits);
        apb_write(uart_data_addr, 32'h69, err, waits);
        // Ten bit times less the setup cycle
        check_value("uart_second_waits", 10 * CLKS_PER_BIT - 1, waits);
        check_value("uart_second_err", 32'd0, {31'd0, err});
        apb_read(uart_stat_addr, rdata, err, waits);
        check_value("uart_busy_second", 32'd1, rdata);
        polls = 0;
        while (rdata[0] && polls < 10 * CLKS_PER_BIT) begin
            apb_read(uart_stat_addr, rdata, err, waits);
            polls++;
        end
        check_value("uart_idle", 32'd0, rdata);
        check_value("uart_byte_count", 32'd2, 32'(rx_bytes.size()));
        if (rx_bytes.size() == 2) begin
            check_value("uart_byte_0", 32'h48, {24'd0, rx_bytes[0]});
            check_value("uart_byte_1", 32'h69, {24'd0, rx_bytes[1]});
        end

        $display("Result: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
source/soc_pkg.sv
source/soc_bus_ctrl.sv
source/onchip_ram.sv
source/ps2_receiver.sv
source/key_irq_ctrl.sv
source/uart_tx_port.sv
source/soc_top.sv
sim/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SoC testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module soc_tb -f compile.f -o soc_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/soc_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

exit 0
